// File: design/constants.svh
// ----------------------------------------------------------------------
// RV32I opcode and funct field constants
// Covers the integer subset that the pipeline decodes
// ----------------------------------------------------------------------
`ifndef CONSTANTS_SVH
`define CONSTANTS_SVH

// Major opcodes
localparam opcode_t OPCODE_OP     = 7'b0110011;
localparam opcode_t OPCODE_OPIMM  = 7'b0010011;
localparam opcode_t OPCODE_LOAD   = 7'b0000011;
localparam opcode_t OPCODE_STORE  = 7'b0100011;
localparam opcode_t OPCODE_BRANCH = 7'b1100011;
localparam opcode_t OPCODE_JAL    = 7'b1101111;
localparam opcode_t OPCODE_JALR   = 7'b1100111;

// funct3 encodings
localparam logic [2:0] F3_ADD_SUB = 3'b000;
localparam logic [2:0] F3_OR      = 3'b110;
localparam logic [2:0] F3_AND     = 3'b111;
localparam logic [2:0] F3_ADDI    = 3'b000;
localparam logic [2:0] F3_LW      = 3'b010;
localparam logic [2:0] F3_SW      = 3'b010;
localparam logic [2:0] F3_BEQ     = 3'b000;
localparam logic [2:0] F3_BNE     = 3'b001;

// funct7 that turns ADD into SUB
localparam logic [6:0] F7_SUB     = 7'b0100000;

`endif

// File: design/hazard_if.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Hazard bus between the datapath and the hazard unit
// Carries stage register indexes up and pipeline control back down
// ----------------------------------------------------------------------
interface hazard_if import pipe_pkg::*; ();

    // Decode stage sources, zero when the field is not a register read
    reg_idx_t d_rs1;
    reg_idx_t d_rs2;

    // ID/EX contents
    reg_idx_t e_rs1;
    reg_idx_t e_rs2;
    reg_idx_t e_rd;
    logic     e_memren;
    logic     e_redirect;

    // EX/MEM and MEM/WB destinations
    reg_idx_t m_rd;
    logic     m_regwren;
    reg_idx_t w_rd;
    logic     w_regwren;

    // Pipeline control, all combinational
    logic     stall_if;
    logic     ifid_wren;
    logic     ifid_flush;
    logic     idex_flush;
    fwd_sel_t rs1_sel;
    fwd_sel_t rs2_sel;

    modport datapath (
        output d_rs1, d_rs2, e_rs1, e_rs2, e_rd, e_memren, e_redirect,
        output m_rd, m_regwren, w_rd, w_regwren,
        input  stall_if, ifid_wren, ifid_flush, idex_flush, rs1_sel, rs2_sel
    );

    modport hazard (
        input  d_rs1, d_rs2, e_rs1, e_rs2, e_rd, e_memren, e_redirect,
        input  m_rd, m_regwren, w_rd, w_regwren,
        output stall_if, ifid_wren, ifid_flush, idex_flush, rs1_sel, rs2_sel
    );

endinterface

// File: design/hazard_unit.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Pipeline hazard unit
// Detects load-use hazards and wrong-path instructions and
// chooses the forwarding source for both EX operands
// Purely combinational so control acts on the next edge
// ----------------------------------------------------------------------
module hazard_unit import pipe_pkg::*; (
    hazard_if.hazard hz
);

    logic load_use;
    logic stall;

    // Newest producer wins
    // x0 is never treated as written so it never forwards
    function automatic fwd_sel_t fwd_src(
        input reg_idx_t rs,
        input reg_idx_t m_rd,
        input logic     m_we,
        input reg_idx_t w_rd,
        input logic     w_we
    );
        if (m_we && (m_rd != '0) && (m_rd == rs)) begin
            fwd_src = FWD_MEM;
        end else if (w_we && (w_rd != '0) && (w_rd == rs)) begin
            fwd_src = FWD_WB;
        end else begin
            fwd_src = FWD_NONE;
        end
    endfunction

    // ------------------------------------------------------------------
    // Load-use detection
    // ------------------------------------------------------------------

    // Load data only exists after MEM
    // A consumer right behind the load has to wait one cycle
    assign load_use = hz.e_memren && (hz.e_rd != '0) &&
                      ((hz.e_rd == hz.d_rs1) || (hz.e_rd == hz.d_rs2));

    // A redirect in EX discards the consumer anyway
    assign stall = load_use && !hz.e_redirect;

    // ------------------------------------------------------------------
    // Stall, bubble and flush
    // ------------------------------------------------------------------

    // Hold PC and IF/ID while the load finishes
    assign hz.stall_if  = stall;
    assign hz.ifid_wren = !stall;

    // Taken branch or jump kills the two younger instructions
    assign hz.ifid_flush = hz.e_redirect;

    // Bubble into EX on a stall as well as on a redirect
    assign hz.idex_flush = load_use || hz.e_redirect;

    // ------------------------------------------------------------------
    // Operand forwarding
    // ------------------------------------------------------------------

    // MEM holds an ALU result, WB holds the final writeback value
    always_comb begin
        hz.rs1_sel = fwd_src(hz.e_rs1, hz.m_rd, hz.m_regwren, hz.w_rd, hz.w_regwren);
        hz.rs2_sel = fwd_src(hz.e_rs2, hz.m_rd, hz.m_regwren, hz.w_rd, hz.w_regwren);
    end

endmodule

// File: design/pipe_datapath.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Five-stage RV32I datapath
// Fetch, decode, execute, memory and writeback with local instruction
// and data memories, pipeline registers and EX forwarding muxes
// Stalls, bubbles and forwarding selects arrive over hazard_if
// ----------------------------------------------------------------------
module pipe_datapath import pipe_pkg::*; #(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
    input  word_t                         imem_wdata,
    hazard_if.datapath                    hz,
    output reg_idx_t                      rf_ra1,
    output reg_idx_t                      rf_ra2,
    input  word_t                         rf_rd1,
    input  word_t                         rf_rd2,
    output logic                          rf_we,
    output reg_idx_t                      rf_wa,
    output word_t                         rf_wd,
    output logic                          wb_valid,
    output reg_idx_t                      wb_rd,
    output word_t                         wb_data
);

    localparam int IA_W = $clog2(IMEM_WORDS);
    localparam int DA_W = $clog2(DMEM_WORDS);

    word_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];

    // Fetch
    word_t pc;
    word_t f_insn;

    // IF/ID
    logic  fd_valid;
    word_t fd_pc;
    word_t fd_insn;

    // Decode
    opcode_t    d_opcode;
    logic [2:0] d_funct3;
    reg_idx_t   d_rs1;
    reg_idx_t   d_rs2;
    word_t      d_imm;
    alu_op_t    d_alu_op;
    logic       d_use_rs1;
    logic       d_use_rs2;
    logic       d_use_imm;
    logic       d_regwren;
    logic       d_memren;
    logic       d_memwren;
    logic       d_branch;
    logic       d_br_ne;
    logic       d_jal;
    logic       d_jalr;

    // ID/EX
    logic     de_valid;
    word_t    de_pc;
    word_t    de_a;
    word_t    de_b;
    word_t    de_imm;
    reg_idx_t de_rs1;
    reg_idx_t de_rs2;
    reg_idx_t de_rd;
    alu_op_t  de_alu_op;
    logic     de_use_imm;
    logic     de_regwren;
    logic     de_memren;
    logic     de_memwren;
    logic     de_branch;
    logic     de_br_ne;
    logic     de_jal;
    logic     de_jalr;

    // Execute
    word_t e_a;
    word_t e_b;
    word_t e_alu_b;
    word_t e_alu;
    word_t e_target;
    logic  e_taken;
    logic  e_redirect;

    // EX/MEM
    logic     em_valid;
    word_t    em_alu;
    word_t    em_sdata;
    reg_idx_t em_rd;
    logic     em_regwren;
    logic     em_memren;
    logic     em_memwren;

    // Memory and MEM/WB
    word_t    m_ld;
    logic     mw_valid;
    word_t    mw_alu;
    word_t    mw_ld;
    reg_idx_t mw_rd;
    logic     mw_regwren;
    logic     mw_memren;
    word_t    w_data;

    // Operand select shared by both EX inputs
    function automatic word_t fwd_pick(
        input fwd_sel_t sel,
        input word_t    idex_val,
        input word_t    mem_val,
        input word_t    wb_val
    );
        case (sel)
            FWD_MEM: fwd_pick = mem_val;
            FWD_WB:  fwd_pick = wb_val;
            default: fwd_pick = idex_val;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // Fetch
    // ------------------------------------------------------------------

    // Program load only while the core is held in reset
    always_ff @(posedge clk) begin
        if (rst && imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    assign f_insn = imem[pc[IA_W+1:2]];

    // Redirect from EX overrides the load-use hold
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (e_redirect) begin
            pc <= e_target;
        end else if (!hz.stall_if) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || hz.ifid_flush) begin
            fd_valid <= 1'b0;
        end else if (hz.ifid_wren) begin
            fd_valid <= 1'b1;
            fd_pc    <= pc;
            fd_insn  <= f_insn;
        end
    end

    // ------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------
    assign d_opcode = fd_insn[6:0];
    assign d_funct3 = fd_insn[14:12];

    always_comb begin
        // I-type immediate unless the format says otherwise
        d_imm     = {{20{fd_insn[31]}}, fd_insn[31:20]};
        d_alu_op  = ALU_ADD;
        d_use_rs1 = 1'b0;
        d_use_rs2 = 1'b0;
        d_use_imm = 1'b0;
        d_regwren = 1'b0;
        d_memren  = 1'b0;
        d_memwren = 1'b0;
        d_branch  = 1'b0;
        d_br_ne   = 1'b0;
        d_jal     = 1'b0;
        d_jalr    = 1'b0;
        case (d_opcode)
            OPCODE_OP: begin
                d_use_rs1 = 1'b1;
                d_use_rs2 = 1'b1;
                d_regwren = (d_funct3 == F3_ADD_SUB) || (d_funct3 == F3_OR) ||
                            (d_funct3 == F3_AND);
                if (d_funct3 == F3_OR) begin
                    d_alu_op = ALU_OR;
                end else if (d_funct3 == F3_AND) begin
                    d_alu_op = ALU_AND;
                end else if (fd_insn[31:25] == F7_SUB) begin
                    d_alu_op = ALU_SUB;
                end
            end
            OPCODE_OPIMM: begin
                d_use_rs1 = 1'b1;
                d_use_imm = 1'b1;
                d_regwren = (d_funct3 == F3_ADDI);
            end
            OPCODE_LOAD: begin
                d_use_rs1 = 1'b1;
                d_use_imm = 1'b1;
                d_regwren = (d_funct3 == F3_LW);
                d_memren  = (d_funct3 == F3_LW);
            end
            OPCODE_STORE: begin
                // S-type offset, rs2 is the store data
                d_imm     = {{20{fd_insn[31]}}, fd_insn[31:25], fd_insn[11:7]};
                d_use_rs1 = 1'b1;
                d_use_rs2 = 1'b1;
                d_use_imm = 1'b1;
                d_memwren = (d_funct3 == F3_SW);
            end
            OPCODE_BRANCH: begin
                d_imm     = {{19{fd_insn[31]}}, fd_insn[31], fd_insn[7],
                             fd_insn[30:25], fd_insn[11:8], 1'b0};
                d_use_rs1 = 1'b1;
                d_use_rs2 = 1'b1;
                d_branch  = (d_funct3 == F3_BEQ) || (d_funct3 == F3_BNE);
                d_br_ne   = (d_funct3 == F3_BNE);
            end
            OPCODE_JAL: begin
                d_imm     = {{11{fd_insn[31]}}, fd_insn[31], fd_insn[19:12],
                             fd_insn[20], fd_insn[30:21], 1'b0};
                d_alu_op  = ALU_PASS_B;
                d_regwren = 1'b1;
                d_jal     = 1'b1;
            end
            OPCODE_JALR: begin
                d_use_rs1 = 1'b1;
                d_alu_op  = ALU_PASS_B;
                d_regwren = 1'b1;
                d_jalr    = 1'b1;
            end
            // Anything else flows down as a NOP
            default: ;
        endcase
    end

    // Unused source fields read as x0 and raise no hazard
    assign d_rs1  = d_use_rs1 ? fd_insn[19:15] : '0;
    assign d_rs2  = d_use_rs2 ? fd_insn[24:20] : '0;
    assign rf_ra1 = d_rs1;
    assign rf_ra2 = d_rs2;

    always_ff @(posedge clk) begin
        if (rst || hz.idex_flush) begin
            de_valid <= 1'b0;
        end else begin
            de_valid   <= fd_valid;
            de_pc      <= fd_pc;
            de_a       <= rf_rd1;
            de_b       <= rf_rd2;
            de_imm     <= d_imm;
            de_rs1     <= d_rs1;
            de_rs2     <= d_rs2;
            de_rd      <= fd_insn[11:7];
            de_alu_op  <= d_alu_op;
            de_use_imm <= d_use_imm;
            de_regwren <= d_regwren;
            de_memren  <= d_memren;
            de_memwren <= d_memwren;
            de_branch  <= d_branch;
            de_br_ne   <= d_br_ne;
            de_jal     <= d_jal;
            de_jalr    <= d_jalr;
        end
    end

    // ------------------------------------------------------------------
    // Execute
    // ------------------------------------------------------------------
    assign e_a = fwd_pick(hz.rs1_sel, de_a, em_alu, w_data);
    assign e_b = fwd_pick(hz.rs2_sel, de_b, em_alu, w_data);

    // Jumps pass the link address straight through the ALU
    assign e_alu_b = (de_jal || de_jalr) ? de_pc + 32'd4 :
                     de_use_imm          ? de_imm        : e_b;

    always_comb begin
        case (de_alu_op)
            ALU_SUB:    e_alu = e_a - e_alu_b;
            ALU_AND:    e_alu = e_a & e_alu_b;
            ALU_OR:     e_alu = e_a | e_alu_b;
            ALU_PASS_B: e_alu = e_alu_b;
            default:    e_alu = e_a + e_alu_b;
        endcase
    end

    // BEQ and BNE share one comparator
    assign e_taken    = de_branch && ((e_a == e_b) != de_br_ne);
    assign e_redirect = de_valid && (e_taken || de_jal || de_jalr);
    assign e_target   = de_jalr ? ((e_a + de_imm) & ~32'd1) : de_pc + de_imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            em_valid <= 1'b0;
        end else begin
            em_valid   <= de_valid;
            em_alu     <= e_alu;
            em_sdata   <= e_b;
            em_rd      <= de_rd;
            em_regwren <= de_regwren;
            em_memren  <= de_memren;
            em_memwren <= de_memwren;
        end
    end

    // ------------------------------------------------------------------
    // Memory and writeback
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (em_valid && em_memwren) begin
            dmem[em_alu[DA_W+1:2]] <= em_sdata;
        end
    end

    assign m_ld = dmem[em_alu[DA_W+1:2]];

    always_ff @(posedge clk) begin
        if (rst) begin
            mw_valid <= 1'b0;
        end else begin
            mw_valid   <= em_valid;
            mw_alu     <= em_alu;
            mw_ld      <= m_ld;
            mw_rd      <= em_rd;
            mw_regwren <= em_regwren;
            mw_memren  <= em_memren;
        end
    end

    assign w_data = mw_memren ? mw_ld : mw_alu;
    assign rf_we  = mw_valid && mw_regwren;
    assign rf_wa  = mw_rd;
    assign rf_wd  = w_data;

    // Retirement report lines up with the register file write edge
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= rf_we && (mw_rd != '0);
            wb_rd    <= mw_rd;
            wb_data  <= w_data;
        end
    end

    // Stage indexes and enables for the hazard unit
    assign hz.d_rs1      = d_rs1;
    assign hz.d_rs2      = d_rs2;
    assign hz.e_rs1      = de_rs1;
    assign hz.e_rs2      = de_rs2;
    assign hz.e_rd       = de_rd;
    assign hz.e_memren   = de_valid && de_memren;
    assign hz.e_redirect = e_redirect;
    assign hz.m_rd       = em_rd;
    assign hz.m_regwren  = em_valid && em_regwren;
    assign hz.w_rd       = mw_rd;
    assign hz.w_regwren  = mw_valid && mw_regwren;

endmodule

// File: design/pipe_pkg.sv
// ----------------------------------------------------------------------
// Shared types for the five-stage pipeline
// Width typedefs, forwarding and ALU enums, opcode constants
// ----------------------------------------------------------------------
package pipe_pkg;

    // Data and instruction word
    typedef logic [31:0] word_t;

    // Register index into x0..x31
    typedef logic [4:0] reg_idx_t;

    // Major opcode field
    typedef logic [6:0] opcode_t;

    // Source of an EX operand
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_MEM  = 2'b01,
        FWD_WB   = 2'b10
    } fwd_sel_t;

    // Operations the EX stage ALU performs
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASS_B
    } alu_op_t;

    // Opcode and funct constants sit on top of opcode_t
    `include "constants.svh"

endpackage

// File: design/pipe_top.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// RV32I five-stage pipeline top level
// Ties the datapath to the register file and hazard unit
// ----------------------------------------------------------------------
module pipe_top import pipe_pkg::*; #(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
    input  word_t                         imem_wdata,
    output logic                          wb_valid,
    output reg_idx_t                      wb_rd,
    output word_t                         wb_data
);

    // Register file wiring
    reg_idx_t rf_ra1;
    reg_idx_t rf_ra2;
    word_t    rf_rd1;
    word_t    rf_rd2;
    logic     rf_we;
    reg_idx_t rf_wa;
    word_t    rf_wd;

    hazard_if hz_bus ();

    pipe_datapath #(
        .IMEM_WORDS (IMEM_WORDS),
        .DMEM_WORDS (DMEM_WORDS)
    ) u_datapath (
        .clk        (clk),
        .rst        (rst),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .hz         (hz_bus.datapath),
        .rf_ra1     (rf_ra1),
        .rf_ra2     (rf_ra2),
        .rf_rd1     (rf_rd1),
        .rf_rd2     (rf_rd2),
        .rf_we      (rf_we),
        .rf_wa      (rf_wa),
        .rf_wd      (rf_wd),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    reg_file u_rf (
        .clk (clk),
        .rst (rst),
        .ra1 (rf_ra1),
        .ra2 (rf_ra2),
        .rd1 (rf_rd1),
        .rd2 (rf_rd2),
        .we  (rf_we),
        .wa  (rf_wa),
        .wd  (rf_wd)
    );

    hazard_unit u_hazard (
        .hz (hz_bus.hazard)
    );

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Integer register file
// 31 storage registers with x0 fixed at zero, two combinational
// read ports and one write port with write-before-read bypass
// ----------------------------------------------------------------------
module reg_file import pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t ra1,
    input  reg_idx_t ra2,
    output word_t    rd1,
    output word_t    rd2,
    input  logic     we,
    input  reg_idx_t wa,
    input  word_t    wd
);

    // No storage behind x0
    word_t regs [1:31];

    // Same-cycle write shows through so decode never waits on WB
    function automatic word_t read_port(input reg_idx_t ra);
        if (ra == '0) begin
            read_port = '0;
        end else if (we && (wa == ra)) begin
            read_port = wd;
        end else begin
            read_port = regs[ra];
        end
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    always_comb begin
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
    end

endmodule

// File: project.f
+incdir+design
design/pipe_pkg.sv
design/hazard_if.sv
design/hazard_unit.sv
design/reg_file.sv
design/pipe_datapath.sv
design/pipe_top.sv
testbench/tb_pipe_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the pipeline testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_pipe_top -o tb_pipe_top
./obj_dir/tb_pipe_top > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

// File: testbench/tb_pipe_top.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Testbench for the five-stage RV32I pipeline
// Loads short programs during reset, predicts the register writes with
// an in-order model and checks every writeback pulse against it
// ----------------------------------------------------------------------
module tb_pipe_top import pipe_pkg::*; ();

    // jal x0, 0 parks the core once a program is done
    localparam word_t SELF_LOOP = 32'h0000006f;

    logic       clk;
    logic       rst;
    logic       imem_we;
    logic [5:0] imem_addr;
    word_t      imem_wdata;
    logic       wb_valid;
    reg_idx_t   wb_rd;
    word_t      wb_data;

    // Program under test and the model's view of data memory
    word_t    prog [8];
    word_t    model_mem [64];
    reg_idx_t exp_rd [$];
    word_t    exp_data [$];

    int got = 0;
    int quiet = 4;
    int check_errs = 0;
    int timeouts = 0;
    int tests = 0;

    pipe_top #(.IMEM_WORDS(64), .DMEM_WORDS(64)) UUT (
        .clk        (clk),
        .rst        (rst),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Instruction encoders
    // ------------------------------------------------------------------
    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPCODE_OP};
    endfunction

    function automatic word_t i_type(input opcode_t op, input logic [2:0] f3,
                                     input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic word_t s_type(input int rs2, input int rs1, input int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), F3_SW, i[4:0], OPCODE_STORE};
    endfunction

    function automatic word_t b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                     input int imm);
        logic [12:0] i;
        i = 13'(imm);
        return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], OPCODE_BRANCH};
    endfunction

    function automatic word_t j_type(input int rd, input int imm);
        logic [20:0] i;
        i = 21'(imm);
        return {i[20], i[10:1], i[11], i[19:12], 5'(rd), OPCODE_JAL};
    endfunction

    // ------------------------------------------------------------------
    // Reference model, runs the program in order until the parking loop
    // ------------------------------------------------------------------
    task automatic predict_writes();
        word_t      regs [32];
        word_t      insn, a, b, v, pc, nxt, addr;
        word_t      imm_i, imm_s, imm_b, imm_j;
        logic [2:0] f3;
        reg_idx_t   rd;
        logic       wr;
        foreach (regs[i]) regs[i] = '0;
        pc = '0;
        for (int step = 0; step < 32; step++) begin
            if (pc >= 32'd32) break;
            insn = prog[pc[4:2]];
            if (insn == SELF_LOOP) break;
            f3    = insn[14:12];
            rd    = insn[11:7];
            a     = regs[insn[19:15]];
            b     = regs[insn[24:20]];
            imm_i = {{20{insn[31]}}, insn[31:20]};
            imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
            imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
            imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
            nxt   = pc + 32'd4;
            wr    = 1'b0;
            v     = '0;
            case (insn[6:0])
                OPCODE_OP: begin
                    wr = 1'b1;
                    case (f3)
                        3'b000:  v = (insn[31:25] == 7'h20) ? a - b : a + b;
                        3'b110:  v = a | b;
                        3'b111:  v = a & b;
                        default: wr = 1'b0;
                    endcase
                end
                OPCODE_OPIMM: begin
                    wr = (f3 == 3'b000);
                    v  = a + imm_i;
                end
                OPCODE_LOAD: begin
                    addr = (a + imm_i) >> 2;
                    wr   = (f3 == 3'b010);
                    v    = model_mem[addr[5:0]];
                end
                OPCODE_STORE: begin
                    addr = (a + imm_s) >> 2;
                    if (f3 == 3'b010) model_mem[addr[5:0]] = b;
                end
                OPCODE_BRANCH: begin
                    if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
                        nxt = pc + imm_b;
                    end
                end
                OPCODE_JAL: begin
                    wr  = 1'b1;
                    v   = pc + 32'd4;
                    nxt = pc + imm_j;
                end
                OPCODE_JALR: begin
                    wr  = 1'b1;
                    v   = pc + 32'd4;
                    nxt = (a + imm_i) & ~32'd1;
                end
                default: ;
            endcase
            // x0 never produces a writeback pulse
            if (wr && rd != '0) begin
                regs[rd] = v;
                exp_rd.push_back(rd);
                exp_data.push_back(v);
            end
            pc = nxt;
        end
    endtask

    // ------------------------------------------------------------------
    // Writeback checker
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        // Nothing may retire in reset or in the first cycles after it
        if (quiet < 4) begin
            assert (wb_valid === 1'b0) else begin
                $display("wb_valid went high during or right after reset at %0t ns", $time);
                check_errs++;
            end
        end else if (wb_valid === 1'b1) begin
            assert (exp_rd.size() != 0) else begin
                $display("Extra write of x%0d at %0t ns that the program never makes",
                         wb_rd, $time);
                check_errs++;
            end
            if (exp_rd.size() != 0) begin
                assert (wb_rd == exp_rd[0] && wb_data == exp_data[0]) else begin
                    $display("Mismatch at %0t ns: expected x%0d = %08h, got x%0d = %08h",
                             $time, exp_rd[0], exp_data[0], wb_rd, wb_data);
                    check_errs++;
                end
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
                got <= got + 1;
            end
        end
        if (rst) quiet <= 0;
        else if (quiet < 4) quiet <= quiet + 1;
    end

    // Reset with program load, then wait for every predicted write
    task automatic run_test(input string name);
        int n_exp;
        int start_got;
        int start_err;
        int waited;
        prog[7] = SELF_LOOP;
        @(negedge clk);
        exp_rd.delete();
        exp_data.delete();
        predict_writes();
        n_exp     = exp_rd.size();
        start_err = check_errs + timeouts;
        // Eight reset cycles, one instruction word per cycle
        @(posedge clk);
        rst        <= 1'b1;
        imem_we    <= 1'b1;
        imem_addr  <= 6'd0;
        imem_wdata <= prog[0];
        for (int i = 1; i < 8; i++) begin
            @(posedge clk);
            imem_addr  <= 6'(i);
            imem_wdata <= prog[i];
        end
        @(posedge clk);
        rst       <= 1'b0;
        imem_we   <= 1'b0;
        start_got = got;
        for (int k = 0; k < n_exp; k++) begin
            waited = 0;
            while (got - start_got <= k && waited < 40) begin
                @(posedge clk);
                waited++;
            end
            if (got - start_got <= k) begin
                $display("Timeout: write %0d of %0d in test %s never retired",
                         k + 1, n_exp, name);
                timeouts++;
                break;
            end
        end
        // Drain so late or extra writes still reach the checker
        repeat (12) @(posedge clk);
        tests++;
        $display("test %-16s %0d of %0d writes  %s", name, got - start_got, n_exp,
                 (check_errs + timeouts == start_err) ? "ok" : "FAILED");
    endtask

    initial begin
        int r1, r2, r3, r4;
        rst        = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        void'($urandom(32'h5ddf05eb));
        r1 = int'($urandom_range(4095, 0));
        r2 = int'($urandom_range(4095, 0));
        r3 = int'($urandom_range(4095, 0));
        r4 = int'($urandom_range(4095, 0));

        // Back-to-back dependencies, MEM forwarding on both operands
        prog[0] = i_type(OPCODE_OPIMM, F3_ADDI, 1, 0, r1);
        prog[1] = i_type(OPCODE_OPIMM, F3_ADDI, 2, 0, r2);
        prog[2] = r_type(7'b0, F3_ADD_SUB, 3, 1, 2);
        prog[3] = r_type(F7_SUB, F3_ADD_SUB, 4, 3, 3);
        prog[4] = r_type(7'b0, F3_OR, 5, 4, 3);
        prog[5] = r_type(7'b0, F3_ADD_SUB, 6, 5, 5);
        prog[6] = r_type(7'b0, F3_AND, 7, 6, 1);
        run_test("alu_mem_fwd");

        // Distance two from WB, and MEM wins over WB for x1
        prog[0] = i_type(OPCODE_OPIMM, F3_ADDI, 1, 0, r3);
        prog[1] = i_type(OPCODE_OPIMM, F3_ADDI, 1, 0, r4);
        prog[2] = r_type(7'b0, F3_ADD_SUB, 2, 1, 1);
        prog[3] = i_type(OPCODE_OPIMM, F3_ADDI, 3, 0, r1);
        prog[4] = i_type(OPCODE_OPIMM, F3_ADDI, 4, 0, r2);
        prog[5] = r_type(7'b0, F3_ADD_SUB, 5, 3, 4);
        prog[6] = r_type(F7_SUB, F3_ADD_SUB, 6, 5, 3);
        run_test("wb_fwd_priority");

        // Store then load, each load used right away
        prog[0] = i_type(OPCODE_OPIMM, F3_ADDI, 1, 0, r2);
        prog[1] = i_type(OPCODE_OPIMM, F3_ADDI, 2, 0, 4 * int'($urandom_range(40, 0)));
        prog[2] = s_type(1, 2, 8);
        prog[3] = i_type(OPCODE_LOAD, F3_LW, 3, 2, 8);
        prog[4] = r_type(7'b0, F3_ADD_SUB, 4, 3, 1);
        prog[5] = i_type(OPCODE_LOAD, F3_LW, 5, 2, 8);
        prog[6] = r_type(F7_SUB, F3_ADD_SUB, 6, 1, 5);
        run_test("load_use");

        // Taken BEQ, JAL and JALR each skip one instruction
        prog[0] = i_type(OPCODE_OPIMM, F3_ADDI, 1, 0, 5);
        prog[1] = b_type(F3_BEQ, 1, 1, 8);
        prog[2] = i_type(OPCODE_OPIMM, F3_ADDI, 2, 0, 1);
        prog[3] = j_type(3, 8);
        prog[4] = i_type(OPCODE_OPIMM, F3_ADDI, 4, 0, 2);
        prog[5] = i_type(OPCODE_JALR, 3'b000, 5, 1, 23);
        prog[6] = i_type(OPCODE_OPIMM, F3_ADDI, 6, 0, 3);
        run_test("redirect");

        // Writes to x0 stay silent and x0 always reads as zero
        prog[0] = i_type(OPCODE_OPIMM, F3_ADDI, 1, 0, r4);
        prog[1] = i_type(OPCODE_OPIMM, F3_ADDI, 0, 1, r3);
        prog[2] = r_type(7'b0, F3_ADD_SUB, 2, 0, 1);
        prog[3] = r_type(7'b0, F3_OR, 0, 1, 1);
        prog[4] = j_type(0, 8);
        prog[5] = i_type(OPCODE_OPIMM, F3_ADDI, 3, 0, 1);
        prog[6] = r_type(7'b0, F3_OR, 4, 0, 0);
        run_test("x0_writes");

        $display("%0d tests, %0d writes checked, %0d check errors, %0d timeouts",
                 tests, got, check_errs, timeouts);
        if (check_errs + timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
